// File: ddsPkg.sv
// Synthesis path widths and the sine waveform used by the phase-to-amplitude stage

package ddsPkg;

	localparam int TuningWidth = 8;		// Tuning word and amplitude
	localparam int PhaseWidth = 16;
	localparam int SampleWidth = 8;
	localparam int IndexWidth = 8;		// Top phase bits that address the wave

	// Offset binary around midscale
	localparam int Midscale = 128;
	localparam int HalfSpan = 127;
	localparam int HalfLength = 1 << (IndexWidth - 1);
	localparam int QuarterShift = 2 * (IndexWidth - 2);

	// Parabolic half waves, close to a sine at this resolution
	// Index 0 is the rising zero crossing, 64 the peak, 192 the trough
	function automatic logic [SampleWidth-1:0] sineSample(
		input logic [IndexWidth-1:0] Index
	);
		int Position;
		int Bulge;
		Position = int'(Index[IndexWidth-2:0]);	// Place within the half wave
		Bulge = (HalfSpan * Position * (HalfLength - Position)) >>> QuarterShift;
		if (Index[IndexWidth-1])
			sineSample = SampleWidth'(Midscale - Bulge);	// Negative half
		else
			sineSample = SampleWidth'(Midscale + Bulge);
	endfunction

endpackage

// File: displayPkg.sv
// Seven-segment display constants and the BCD to segment decoder

package displayPkg;

	localparam int DigitCount = 8;
	localparam int BcdWidth = 4;
	localparam int SegmentWidth = 8;

	// Active low, every segment dark
	localparam logic [SegmentWidth-1:0] SegmentsOff = '1;

	// Segment word is {dp, g, f, e, d, c, b, a}, active low
	// Decimal point stays dark, codes above 9 blank the digit
	function automatic logic [SegmentWidth-1:0] segmentPattern(
		input logic [BcdWidth-1:0] Digit
	);
		case (Digit)
			4'd0: segmentPattern = 8'hC0;
			4'd1: segmentPattern = 8'hF9;
			4'd2: segmentPattern = 8'hA4;
			4'd3: segmentPattern = 8'hB0;
			4'd4: segmentPattern = 8'h99;
			4'd5: segmentPattern = 8'h92;
			4'd6: segmentPattern = 8'h82;
			4'd7: segmentPattern = 8'hF8;
			4'd8: segmentPattern = 8'h80;
			4'd9: segmentPattern = 8'h90;
			default: segmentPattern = SegmentsOff;
		endcase
	endfunction

endpackage

// File: Encoder.sv
// Quadrature encoder front end giving one step pulse per detent
`timescale 1ns/1ps
`default_nettype none

module Encoder #(
	parameter int DebounceCycles = 1000
)(
	input logic Clock,
	input logic Reset,
	input logic A_i,
	input logic B_i,
	output logic Increment_o,
	output logic Decrement_o
);

	localparam logic [1:0] RestState = 2'b11;	// Detent with both lines pulled high
	localparam int TimerWidth = $clog2(DebounceCycles + 1);

	logic [1:0] SyncFirst;
	logic [1:0] SyncSecond;
	logic [1:0] Stable;				// Debounced {A, B}
	logic [TimerWidth-1:0] StableTimer;
	logic Accept;
	logic SingleChange;
	logic Forward;
	logic Backward;
	logic signed [3:0] StepCount;
	logic signed [3:0] NextCount;

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			SyncFirst <= RestState;
			SyncSecond <= RestState;
		end else begin
			SyncFirst <= {A_i, B_i};
			SyncSecond <= SyncFirst;
		end
	end

	// A new level has to hold for DebounceCycles before it counts
	assign Accept = (SyncSecond != Stable) && (StableTimer == TimerWidth'(DebounceCycles - 1));

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			Stable <= RestState;
			StableTimer <= '0;
		end else if (SyncSecond == Stable) begin
			StableTimer <= '0;
		end else if (Accept) begin
			Stable <= SyncSecond;
			StableTimer <= '0;
		end else begin
			StableTimer <= StableTimer + 1'b1;
		end
	end

	// Forward order is 11, 01, 00, 10 with A moving first
	assign SingleChange = ^(SyncSecond ^ Stable);
	assign Forward = Accept && SingleChange && !(Stable[1] ^ SyncSecond[0]);
	assign Backward = Accept && SingleChange && (Stable[1] ^ SyncSecond[0]);

	always_comb begin
		NextCount = StepCount;
		if (Forward)
			NextCount = StepCount + 4'sd1;
		else if (Backward)
			NextCount = StepCount - 4'sd1;
	end

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			StepCount <= '0;
			Increment_o <= 1'b0;
			Decrement_o <= 1'b0;
		end else begin
			Increment_o <= 1'b0;
			Decrement_o <= 1'b0;
			if (Accept && SyncSecond == RestState) begin
				Increment_o <= (NextCount == 4'sd4);	// Full detent only
				Decrement_o <= (NextCount == -4'sd4);
				StepCount <= '0;
			end else begin
				StepCount <= NextCount;
			end
		end
	end

endmodule

`default_nettype wire

// File: Dds.sv
// Direct digital synthesis core with tuning word, phase accumulator and sine lookup
`timescale 1ns/1ps
`default_nettype none

module Dds (
	input logic Clock,
	input logic Reset,
	input logic Increment_i,
	input logic Decrement_i,
	output logic [ddsPkg::SampleWidth-1:0] Sample_o,
	output logic Overflow_o
);

	localparam int SumWidth = ddsPkg::PhaseWidth + 1;

	logic [ddsPkg::TuningWidth-1:0] TuningWord;
	logic [ddsPkg::PhaseWidth-1:0] Phase;
	logic [SumWidth-1:0] PhaseSum;			// Carry in the top bit
	logic [ddsPkg::IndexWidth-1:0] TableIndex;

	// Increment wins when both pulses arrive
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset)
			TuningWord <= '0;
		else if (Increment_i)
			TuningWord <= TuningWord + 1'b1;
		else if (Decrement_i)
			TuningWord <= TuningWord - 1'b1;
	end

	assign PhaseSum = {1'b0, Phase} + SumWidth'(TuningWord);

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			Phase <= '0;
			Overflow_o <= 1'b0;
		end else begin
			Phase <= PhaseSum[ddsPkg::PhaseWidth-1:0];
			Overflow_o <= PhaseSum[ddsPkg::PhaseWidth];	// One pulse per wrap
		end
	end

	assign TableIndex = Phase[ddsPkg::PhaseWidth-1 -: ddsPkg::IndexWidth];

	// Sample trails the phase by one cycle
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset)
			Sample_o <= ddsPkg::sineSample('0);	// Midscale, matches phase zero
		else
			Sample_o <= ddsPkg::sineSample(TableIndex);
	end

endmodule

`default_nettype wire

// File: OutputScaler.sv
// Amplitude control that scales each sample by an 8-bit gain
`timescale 1ns/1ps
`default_nettype none

module OutputScaler (
	input logic Clock,
	input logic Reset,
	input logic Increment_i,
	input logic Decrement_i,
	input logic [ddsPkg::SampleWidth-1:0] Sample_i,
	output logic [ddsPkg::SampleWidth-1:0] Signal_o
);

	localparam int ProductWidth = ddsPkg::SampleWidth + ddsPkg::TuningWidth;

	logic [ddsPkg::TuningWidth-1:0] Amplitude;
	logic [ProductWidth-1:0] Product;

	// Full scale after reset, wraps both ways
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset)
			Amplitude <= '1;
		else if (Increment_i)
			Amplitude <= Amplitude + 1'b1;
		else if (Decrement_i)
			Amplitude <= Amplitude - 1'b1;
	end

	assign Product = Sample_i * Amplitude;

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset)
			Signal_o <= '0;
		else
			Signal_o <= Product[ProductWidth-1 -: ddsPkg::SampleWidth];	// High byte
	end

endmodule

`default_nettype wire

// File: SevenSegmentMux.sv
// Multiplexed scan of eight BCD digits onto a common-anode display
`timescale 1ns/1ps
`default_nettype none

module SevenSegmentMux #(
	parameter int ScanCycles = 25_000
)(
	input logic Clock,
	input logic Reset,
	input logic [displayPkg::DigitCount*displayPkg::BcdWidth-1:0] Digits_i,
	output logic [displayPkg::DigitCount-1:0] Cathodes_o,
	output logic [displayPkg::SegmentWidth-1:0] Segments_o
);

	localparam int TimerWidth = $clog2(ScanCycles + 1);
	localparam int IndexWidth = $clog2(displayPkg::DigitCount);
	localparam logic [displayPkg::DigitCount-1:0] FirstCathode = 1;

	logic [TimerWidth-1:0] ScanTimer;
	logic ScanStep;
	logic [IndexWidth-1:0] DigitIndex;
	logic [displayPkg::BcdWidth-1:0] CurrentDigit;

	assign ScanStep = (ScanTimer == TimerWidth'(ScanCycles - 1));

	// Each digit stays lit for ScanCycles
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			ScanTimer <= '0;
			DigitIndex <= '0;
		end else if (ScanStep) begin
			ScanTimer <= '0;
			if (DigitIndex == IndexWidth'(displayPkg::DigitCount - 1))
				DigitIndex <= '0;
			else
				DigitIndex <= DigitIndex + 1'b1;
		end else begin
			ScanTimer <= ScanTimer + 1'b1;
		end
	end

	assign CurrentDigit = Digits_i[DigitIndex*displayPkg::BcdWidth +: displayPkg::BcdWidth];

	// Active-low one-hot cathode, segments follow the same index
	assign Cathodes_o = ~(FirstCathode << DigitIndex);
	assign Segments_o = displayPkg::segmentPattern(CurrentDigit);

endmodule

`default_nettype wire

// File: FrequencyMeter.sv
// Gated overflow counter with decimal conversion for the seven-segment display
`timescale 1ns/1ps
`default_nettype none

module FrequencyMeter #(
	parameter int ClockHz = 25_000_000,
	parameter int ScanCycles = 25_000
)(
	input logic Clock,
	input logic Reset,
	input logic Overflow_i,
	output logic [displayPkg::DigitCount-1:0] Cathodes_o,
	output logic [displayPkg::SegmentWidth-1:0] Segments_o
);

	localparam int GateWidth = $clog2(ClockHz);
	localparam int CountWidth = $clog2(ClockHz + 1);	// At most one overflow per cycle
	localparam int BcdBits = displayPkg::DigitCount * displayPkg::BcdWidth;
	localparam int StepWidth = $clog2(CountWidth + 1);

	logic [GateWidth-1:0] GateTimer;
	logic GateEnd;
	logic [CountWidth-1:0] OverflowCount;
	logic [CountWidth-1:0] BinaryShift;
	logic [BcdBits-1:0] BcdWork;
	logic [BcdBits-1:0] BcdAdjusted;
	logic [StepWidth-1:0] BitsLeft;
	logic [BcdBits-1:0] Digits;			// Last complete gate

	// One second gate
	assign GateEnd = (GateTimer == GateWidth'(ClockHz - 1));

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			GateTimer <= '0;
			OverflowCount <= '0;
		end else if (GateEnd) begin
			GateTimer <= '0;
			OverflowCount <= '0;
		end else begin
			GateTimer <= GateTimer + 1'b1;
			if (Overflow_i)
				OverflowCount <= OverflowCount + 1'b1;
		end
	end

	// Double dabble, add 3 to every digit of 5 or more before the shift
	always_comb begin
		for (int Digit = 0; Digit < displayPkg::DigitCount; Digit++) begin
			if (BcdWork[Digit*displayPkg::BcdWidth +: displayPkg::BcdWidth] >= 4'd5)
				BcdAdjusted[Digit*displayPkg::BcdWidth +: displayPkg::BcdWidth] =
					BcdWork[Digit*displayPkg::BcdWidth +: displayPkg::BcdWidth] + 4'd3;
			else
				BcdAdjusted[Digit*displayPkg::BcdWidth +: displayPkg::BcdWidth] =
					BcdWork[Digit*displayPkg::BcdWidth +: displayPkg::BcdWidth];
		end
	end

	// Latch the count at gate end, one bit shifted per cycle after that
	always_ff @(posedge Clock) begin
		if (GateEnd) begin
			BinaryShift <= OverflowCount + CountWidth'(Overflow_i);	// Last cycle counts too
			BcdWork <= '0;
		end else if (BitsLeft != '0) begin
			{BcdWork, BinaryShift} <= {BcdAdjusted, BinaryShift} << 1;
		end
	end

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			BitsLeft <= '0;
			Digits <= '0;
		end else if (GateEnd) begin
			BitsLeft <= StepWidth'(CountWidth);
		end else if (BitsLeft != '0) begin
			BitsLeft <= BitsLeft - 1'b1;
			if (BitsLeft == StepWidth'(1))
				Digits <= {BcdAdjusted[BcdBits-2:0], BinaryShift[CountWidth-1]};
		end
	end

	SevenSegmentMux #(
		.ScanCycles(ScanCycles)
	) SegmentMux_inst (
		.Clock(Clock),
		.Reset(Reset),
		.Digits_i(Digits),
		.Cathodes_o(Cathodes_o),
		.Segments_o(Segments_o)
	);

endmodule

`default_nettype wire

// File: top.sv
// Signal generator top with encoder control, DDS, output scaling and frequency display
`timescale 1ns/1ps
`default_nettype none

module top #(
	parameter int ClockHz = 25_000_000,
	parameter int DebounceCycles = 1000,
	parameter int ScanCycles = 25_000
)(
	input logic Clock,
	input logic Reset,
	input logic EncoderFreqA_i,
	input logic EncoderFreqB_i,
	input logic EncoderAmplA_i,
	input logic EncoderAmplB_i,
	output logic [ddsPkg::SampleWidth-1:0] Signal_o,
	output logic [displayPkg::DigitCount-1:0] Cathodes_o,
	output logic [displayPkg::SegmentWidth-1:0] Segments_o
);

	logic IncrementFreq;
	logic DecrementFreq;
	logic IncrementAmpl;
	logic DecrementAmpl;
	logic Overflow;
	logic [ddsPkg::SampleWidth-1:0] Sample;

	// Frequency knob
	Encoder #(
		.DebounceCycles(DebounceCycles)
	) EncoderFreq_inst (
		.Clock(Clock),
		.Reset(Reset),
		.A_i(EncoderFreqA_i),
		.B_i(EncoderFreqB_i),
		.Increment_o(IncrementFreq),
		.Decrement_o(DecrementFreq)
	);

	// Amplitude knob
	Encoder #(
		.DebounceCycles(DebounceCycles)
	) EncoderAmpl_inst (
		.Clock(Clock),
		.Reset(Reset),
		.A_i(EncoderAmplA_i),
		.B_i(EncoderAmplB_i),
		.Increment_o(IncrementAmpl),
		.Decrement_o(DecrementAmpl)
	);

	Dds Dds_inst (
		.Clock(Clock),
		.Reset(Reset),
		.Increment_i(IncrementFreq),
		.Decrement_i(DecrementFreq),
		.Sample_o(Sample),
		.Overflow_o(Overflow)
	);

	OutputScaler OutputScaler_inst (
		.Clock(Clock),
		.Reset(Reset),
		.Increment_i(IncrementAmpl),
		.Decrement_i(DecrementAmpl),
		.Sample_i(Sample),
		.Signal_o(Signal_o)
	);

	// Counts accumulator wraps per second
	FrequencyMeter #(
		.ClockHz(ClockHz),
		.ScanCycles(ScanCycles)
	) FrequencyMeter_inst (
		.Clock(Clock),
		.Reset(Reset),
		.Overflow_i(Overflow),
		.Cathodes_o(Cathodes_o),
		.Segments_o(Segments_o)
	);

endmodule

`default_nettype wire

// File: GeneratorTb.sv
// Signal generator testbench that replays the testdata file against the top level
`timescale 1ns/1ps

module GeneratorTb;

	localparam int ClockHz = 65536;
	localparam int DebounceCycles = 8;
	localparam int ScanCycles = 16;
	localparam int PhaseCycles = 20;	// Hold time of each quadrature phase
	localparam int MaxLines = 64;

	logic Clock;
	logic Reset;
	logic EncoderFreqA;
	logic EncoderFreqB;
	logic EncoderAmplA;
	logic EncoderAmplB;
	logic [ddsPkg::SampleWidth-1:0] Signal;
	logic [displayPkg::DigitCount-1:0] Cathodes;
	logic [displayPkg::SegmentWidth-1:0] Segments;

	logic [15:0] TestData [0:3*MaxLines-1];	// Operation, count, expected per line
	int Cycles;
	int CycleLimit;
	int Errors;
	int Passed;
	int Failed;
	int LastChange;
	logic [ddsPkg::TuningWidth-1:0] ModelTuning;
	logic [ddsPkg::TuningWidth-1:0] ModelAmplitude;
	logic [ddsPkg::PhaseWidth-1:0] ModelPhase;

	top #(
		.ClockHz(ClockHz),
		.DebounceCycles(DebounceCycles),
		.ScanCycles(ScanCycles)
	) uut (
		.Clock(Clock),
		.Reset(Reset),
		.EncoderFreqA_i(EncoderFreqA),
		.EncoderFreqB_i(EncoderFreqB),
		.EncoderAmplA_i(EncoderAmplA),
		.EncoderAmplB_i(EncoderAmplB),
		.Signal_o(Signal),
		.Cathodes_o(Cathodes),
		.Segments_o(Segments)
	);

	always #2 Clock = ~Clock;

	always @(posedge Clock) begin
		Cycles <= Cycles + 1;
		if (Cycles >= CycleLimit) begin
			$display("Timeout after %0d cycles, the tests did not finish", Cycles);
			$display("Test failed");
			$finish;
		end
	end

	task automatic compare(input string Name, input int Expected, input int Actual);
		if (Expected != Actual) begin
			$display("Mismatch %s expected %0d actual %0d", Name, Expected, Actual);
			Errors++;
		end
	endtask

	task automatic reportTest(input string Name, input int ErrorsBefore);
		if (Errors == ErrorsBefore) begin
			Passed++;
			$display("%s ok", Name);
		end else begin
			Failed++;
			$display("%s FAILED", Name);
		end
	endtask

	// True when the model phase addresses table entry 0 or 128 at midscale
	function automatic bit atMidscale(input int Now);
		logic [ddsPkg::PhaseWidth-1:0] Phase;
		Phase = ModelPhase + ddsPkg::PhaseWidth'(ModelTuning * (Now - LastChange));
		return Phase[14:8] == 0;
	endfunction

	// One detent with A leading for up and B leading for down
	task automatic turnKnob(input bit Frequency, input bit Up, input bit Align, output int Start);
		logic [1:0] Pins;
		@(posedge Clock);
		while (Align && !atMidscale(Cycles))
			@(posedge Clock);
		Start = Cycles;
		for (int Phase = 0; Phase < 4; Phase++) begin
			case (Phase)
				0: Pins = 2'b01;
				1: Pins = 2'b00;
				2: Pins = 2'b10;
				default: Pins = 2'b11;	// Back at rest
			endcase
			if (!Up)
				Pins = {Pins[0], Pins[1]};
			if (Phase != 0)
				repeat (PhaseCycles) @(posedge Clock);
			if (Frequency)
				{EncoderFreqA, EncoderFreqB} <= Pins;
			else
				{EncoderAmplA, EncoderAmplB} <= Pins;
		end
		repeat (PhaseCycles) @(posedge Clock);
	endtask

	// Every pulse lags its step by the same delay so the model integrates from each step start
	task automatic stepFrequency(input bit Up);
		logic [ddsPkg::TuningWidth-1:0] NextTuning;
		int Start;
		NextTuning = Up ? ModelTuning + 1'b1 : ModelTuning - 1'b1;
		turnKnob(1'b1, Up, NextTuning == 0, Start);
		ModelPhase = ModelPhase + ddsPkg::PhaseWidth'(ModelTuning * (Start - LastChange));
		LastChange = Start;
		ModelTuning = NextTuning;
	endtask

	task automatic readDisplay(output int Value);
		int Weight;
		int Digit;
		Value = 0;
		Weight = 1;
		for (int Index = 0; Index < displayPkg::DigitCount; Index++) begin
			@(negedge Clock);
			while (Cathodes != ~(8'b1 << Index))
				@(negedge Clock);
			Digit = -1;
			for (int Code = 0; Code < 10; Code++)
				if (displayPkg::segmentPattern(4'(Code)) == Segments)
					Digit = Code;
			if (Digit < 0) begin
				$display("Display digit %0d shows a pattern that is no decimal digit", Index);
				Errors++;
			end else begin
				Value += Digit * Weight;
			end
			Weight *= 10;
		end
	endtask

	initial begin
		int NumLines;
		int Op;
		int Count;
		int Expected;
		int Value;
		int Start;
		int ErrorsBefore;
		int DisplayLines;
		int FreqLines;
		int StepTotal;
		string Name;
		Clock = 1'b0;
		Reset = 1'b0;
		{EncoderFreqA, EncoderFreqB, EncoderAmplA, EncoderAmplB} = 4'b1111;
		{Errors, Passed, Failed, LastChange} = '0;
		{NumLines, DisplayLines, FreqLines, StepTotal} = '0;
		ModelTuning = '0;
		ModelAmplitude = '1;
		ModelPhase = '0;
		$readmemh("generator_testdata.txt", TestData);
		while (NumLines < MaxLines && TestData[3*NumLines] >= 1
				&& TestData[3*NumLines] <= 6) begin
			Op = TestData[3*NumLines];
			if (Op == 6)
				DisplayLines++;
			if (Op <= 4)
				StepTotal += TestData[3*NumLines+1];
			if (Op <= 2)
				FreqLines++;	// May wait up to half a gate for midscale
			NumLines++;
		end
		CycleLimit = DisplayLines * 3 * ClockHz + FreqLines * ClockHz / 2
			+ StepTotal * 200 + 10000;
		if (NumLines == 0) begin
			$display("No test lines could be read from generator_testdata.txt");
			Errors++;
		end
		repeat (5) @(posedge Clock);
		Reset <= 1'b1;
		for (int Line = 0; Line < NumLines; Line++) begin
			Op = TestData[3*Line];
			Count = TestData[3*Line+1];
			Expected = TestData[3*Line+2];
			ErrorsBefore = Errors;
			case (Op)
				1, 2: repeat (Count) stepFrequency(Op == 1);
				3, 4: begin
					for (int Step = 0; Step < Count; Step++) begin
						turnKnob(1'b0, Op == 3, 1'b0, Start);
						ModelAmplitude = (Op == 3) ? ModelAmplitude + 1'b1 : ModelAmplitude - 1'b1;
					end
				end
				5: begin
					$sformat(Name, "line %0d signal", Line);
					repeat (8) @(posedge Clock);
					@(negedge Clock);
					if (ModelTuning != 0) begin
						$display("%s asks for a level check while the tuning word is not 0", Name);
						Errors++;
					end
					compare({Name, " data"}, (128 * ModelAmplitude) >> 8, Expected);
					compare(Name, Expected, Signal);
					reportTest(Name, ErrorsBefore);
				end
				default: begin
					$sformat(Name, "line %0d display", Line);
					repeat (2 * ClockHz + 64) @(posedge Clock);	// Two gates plus conversion
					readDisplay(Value);
					compare({Name, " data"}, ModelTuning, Expected);
					compare(Name, Expected, Value);
					reportTest(Name, ErrorsBefore);
				end
			endcase
		end
		$display("Checks ok %0d, checks failed %0d, errors %0d", Passed, Failed, Errors);
		if (Errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: generator_testdata.txt
// Columns in hex: operation, count, expected value
// 1 freq up, 2 freq down, 3 ampl up, 4 ampl down, 5 check signal, 6 check display
0005 0000 007F
0006 0000 0000
0004 0003 0000
0005 0000 007E
0003 0004 0000
0005 0000 0000
0004 0001 0000
0005 0000 007F
0004 0040 0000
0005 0000 005F
0001 0025 0000
0006 0000 0025
0002 002B 0000
0006 0000 00FA
0003 0010 0000
0006 0000 00FA
0001 0006 0000
0005 0000 0067
0006 0000 0000

// File: verilog.f
ddsPkg.sv
displayPkg.sv
Encoder.sv
Dds.sv
OutputScaler.sv
SevenSegmentMux.sv
FrequencyMeter.sv
top.sv
GeneratorTb.sv

// File: Bender.yml
package:
  name: dds_generator

sources:
  - ddsPkg.sv
  - displayPkg.sv
  - Encoder.sv
  - Dds.sv
  - OutputScaler.sv
  - SevenSegmentMux.sv
  - FrequencyMeter.sv
  - top.sv
  - target: simulation
    files:
      - GeneratorTb.sv
